/* src/retire_mon_pkg.sv */
// Shared constants for the retire mix monitor
// Opcodes, window markers, category positions, widths and instruction word view
`default_nettype none

package retire_mon_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes

    localparam int instr_w    = 32;
    localparam int num_cats   = 7;
    localparam int cat_idx_w  = 3;
    localparam int count_w    = 32;
    localparam int fifo_depth = 8;
    localparam int fifo_ptr_w = $clog2(fifo_depth);

    //////////////////////////////////////////////////
    // Major opcodes, instruction bits 6:2

    localparam logic [4:0] opc_load      = 5'b00000;
    localparam logic [4:0] opc_fence     = 5'b00011;
    localparam logic [4:0] opc_arith_imm = 5'b00100;
    localparam logic [4:0] opc_auipc     = 5'b00101;
    localparam logic [4:0] opc_store     = 5'b01000;
    localparam logic [4:0] opc_amo       = 5'b01011;
    localparam logic [4:0] opc_arith     = 5'b01100;
    localparam logic [4:0] opc_lui       = 5'b01101;
    localparam logic [4:0] opc_branch    = 5'b11000;
    localparam logic [4:0] opc_jalr      = 5'b11001;
    localparam logic [4:0] opc_jal       = 5'b11011;
    localparam logic [4:0] opc_system    = 5'b11100;

    // Collection window markers
    // Both are addi x0, x0, imm so they retire as harmless no-ops
    localparam logic [instr_w-1:0] start_marker = 32'h00C0_0013;
    localparam logic [instr_w-1:0] end_marker   = 32'h00D0_0013;

    //////////////////////////////////////////////////
    // Category mask bit positions
    // Same order is used for the report index

    localparam int cat_alu   = 0;
    localparam int cat_br    = 1;
    localparam int cat_mul   = 2;
    localparam int cat_div   = 3;
    localparam int cat_load  = 4;
    localparam int cat_store = 5;
    localparam int cat_misc  = 6;

    //////////////////////////////////////////////////
    // Instruction word

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_fields_t;

    // Raw view for marker compare, field view for decode
    typedef union packed {
        logic [instr_w-1:0] raw;
        rv_fields_t         f;
    } instr_word_u;

endpackage

`default_nettype wire

/* src/retire_event_if.sv */
// Classified retire event channel with valid/ready handshake
`default_nettype none

interface retire_event_if
    import retire_mon_pkg::*;
();

    logic                valid;
    logic                ready;
    // One bit per counted category
    logic [num_cats-1:0] cat_mask;
    logic                is_start;
    logic                is_end;

    modport sender (
        output valid,
        output cat_mask,
        output is_start,
        output is_end,
        input  ready
    );

    modport receiver (
        input  valid,
        input  cat_mask,
        input  is_start,
        input  is_end,
        output ready
    );

endinterface

`default_nettype wire

/* src/retire_classifier.sv */
// Retire stream decoder
// Tracks the collection window, builds category masks, flags lost events
`default_nettype none

module retire_classifier
    import retire_mon_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  retire_valid,
    input  wire instr_word_u     retire_instr,
    retire_event_if.sender       ev,
    output logic                 overflow
);

    logic                window_open;
    logic                is_start_instr;
    logic                is_end_instr;
    logic [4:0]          opc;
    logic                arith_m;
    logic [num_cats-1:0] mask;
    logic                emit;

    //////////////////////////////////////////////////
    // Decode

    assign is_start_instr = (retire_instr.raw == start_marker);
    assign is_end_instr   = (retire_instr.raw == end_marker);

    always_comb begin
        opc = retire_instr.f.opcode[6:2];
        // M extension only lives in the register-register arith space
        arith_m = (opc == opc_arith) && retire_instr.f.funct7[0];

        mask = '0;
        mask[cat_alu]   = (opc inside {opc_arith, opc_arith_imm, opc_auipc, opc_lui})
                          && !arith_m;
        mask[cat_br]    = opc inside {opc_branch, opc_jal, opc_jalr};
        mask[cat_mul]   = arith_m && !retire_instr.f.funct3[2];
        mask[cat_div]   = arith_m && retire_instr.f.funct3[2];
        // AMO is both a load and a store
        mask[cat_load]  = opc inside {opc_load, opc_amo};
        mask[cat_store] = opc inside {opc_store, opc_amo};
        mask[cat_misc]  = opc inside {opc_system, opc_fence};

        // Markers decode as addi but are never counted
        if (is_start_instr || is_end_instr) begin
            mask = '0;
        end
    end

    // Start always restarts, the rest only matters inside the window
    assign emit = retire_valid &&
                  (is_start_instr || (window_open && (is_end_instr || (|mask))));

    //////////////////////////////////////////////////
    // Window and output stage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_open <= 1'b0;
            ev.valid    <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            if (retire_valid && is_start_instr) begin
                window_open <= 1'b1;
            end else if (retire_valid && is_end_instr) begin
                window_open <= 1'b0;
            end
            // Single stage only, an unaccepted event is dropped
            ev.valid <= emit;
            overflow <= overflow | (ev.valid & ~ev.ready);
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            ev.cat_mask <= mask;
            ev.is_start <= is_start_instr;
            ev.is_end   <= is_end_instr;
        end
    end

endmodule

`default_nettype wire

/* src/event_fifo.sv */
// Circular event buffer between classifier and counter bank
// In-order, ready drops only when all entries are in use
`default_nettype none

module event_fifo
    import retire_mon_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    retire_event_if.receiver in_ev,
    retire_event_if.sender   out_ev
);

    // Entry layout is {is_start, is_end, cat_mask}
    logic [num_cats+1:0]   mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w:0]   count;
    logic                  push;
    logic                  pop;

    //////////////////////////////////////////////////
    // Handshakes

    assign in_ev.ready  = (count != (fifo_ptr_w + 1)'(fifo_depth));
    assign out_ev.valid = (count != '0);

    assign push = in_ev.valid && in_ev.ready;
    assign pop  = out_ev.valid && out_ev.ready;

    //////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in_ev.is_start, in_ev.is_end, in_ev.cat_mask};
        end
    end

    // Head entry is presented straight from the array
    assign {out_ev.is_start, out_ev.is_end, out_ev.cat_mask} = mem[rd_ptr];

    //////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // Both or neither, occupancy unchanged
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mix_counter_bank.sv */
// Per-category instruction counters and report stream
// Start clears, counting events increment, end triggers the report
`default_nettype none

module mix_counter_bank
    import retire_mon_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    retire_event_if.receiver      ev,
    output logic                  report_valid,
    input  wire                   report_ready,
    output logic [cat_idx_w-1:0]  report_cat,
    output logic [count_w-1:0]    report_count,
    output logic                  report_last
);

    logic [count_w-1:0]   cnt [num_cats];
    logic                 reporting;
    logic [cat_idx_w-1:0] idx;
    logic                 take;
    logic                 beat;
    logic                 at_last;

    //////////////////////////////////////////////////
    // Event side

    // Events wait in the buffer while the report is out
    assign ev.ready = !reporting;
    assign take     = ev.valid && ev.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_cats; i++) begin
                cnt[i] <= '0;
            end
        end else if (take) begin
            for (int i = 0; i < num_cats; i++) begin
                if (ev.is_start) begin
                    cnt[i] <= '0;
                end else if (ev.cat_mask[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Report side

    assign at_last = (idx == cat_idx_w'(num_cats - 1));
    assign beat    = report_valid && report_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reporting <= 1'b0;
            idx       <= '0;
        end else if (reporting) begin
            if (beat) begin
                if (at_last) begin
                    reporting <= 1'b0;
                    idx       <= '0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end else if (take && ev.is_end) begin
            // First beat goes out next cycle
            reporting <= 1'b1;
            idx       <= '0;
        end
    end

    // Payload follows idx, so it holds while stalled
    assign report_valid = reporting;
    assign report_cat   = idx;
    assign report_count = cnt[idx];
    assign report_last  = reporting && at_last;

endmodule

`default_nettype wire

/* src/retire_mix_monitor.sv */
// Retire instruction mix monitor top level
// Classifier, event buffer and counter bank joined by two event channels
`default_nettype none

module retire_mix_monitor
    import retire_mon_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,

    // Retire trace input
    input  wire                   retire_valid,
    input  wire [instr_w-1:0]     retire_instr,

    // Report stream
    input  wire                   report_ready,
    output logic                  report_valid,
    output logic [cat_idx_w-1:0]  report_cat,
    output logic [count_w-1:0]    report_count,
    output logic                  report_last,

    // Sticky lost-event flag
    output logic                  overflow
);

    retire_event_if cls_ev ();
    retire_event_if cnt_ev ();

    //////////////////////////////////////////////////
    // Decode and window tracking
    retire_classifier u_classifier (
        .clk          (clk),
        .rst_n        (rst_n),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .ev           (cls_ev.sender),
        .overflow     (overflow)
    );

    // Absorbs events while a report is in progress
    event_fifo u_event_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_ev  (cls_ev.receiver),
        .out_ev (cnt_ev.sender)
    );

    //////////////////////////////////////////////////
    // Counting and report
    mix_counter_bank u_counter_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .ev           (cnt_ev.receiver),
        .report_valid (report_valid),
        .report_ready (report_ready),
        .report_cat   (report_cat),
        .report_count (report_count),
        .report_last  (report_last)
    );

endmodule

`default_nettype wire

/* tests/retire_mix_properties.sv */
// Concurrent checks on the report stream and the event buffer
// Bound into mix_counter_bank and event_fifo
`default_nettype none

module retire_mix_properties
    import retire_mon_pkg::*;
(
    input wire                 clk,
    input wire                 rst_n,
    input wire                 report_valid,
    input wire                 report_ready,
    input wire [cat_idx_w-1:0] report_cat,
    input wire [count_w-1:0]   report_count,
    input wire                 report_last,
    input wire                 fifo_push,
    input wire [fifo_ptr_w:0]  fifo_count
);

    // Stalled beat keeps its payload
    a_report_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (report_valid && !report_ready) |=>
            (report_valid && $stable(report_cat) && $stable(report_count)
             && $stable(report_last)))
        else $error("report payload changed while stalled");

    a_last_at_final: assert property (@(posedge clk) disable iff (!rst_n)
        report_last |-> (report_valid && report_cat == cat_idx_w'(num_cats - 1)))
        else $error("report_last outside the final index");

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_push |-> (fifo_count != (fifo_ptr_w + 1)'(fifo_depth)))
        else $error("event buffer accepted an event while full");

endmodule

bind mix_counter_bank retire_mix_properties props_report (
    .clk(clk), .rst_n(rst_n), .report_valid(report_valid), .report_ready(report_ready),
    .report_cat(report_cat), .report_count(report_count), .report_last(report_last),
    .fifo_push(1'b0), .fifo_count('0)
);

bind event_fifo retire_mix_properties props_fifo (
    .clk(clk), .rst_n(rst_n), .report_valid(1'b0), .report_ready(1'b0),
    .report_cat('0), .report_count('0), .report_last(1'b0),
    .fifo_push(push), .fifo_count(count)
);

`default_nettype wire

/* tests/tb_retire_mix_monitor.sv */
// Testbench for the retire mix monitor
// Random and directed windows, reference mask model, report comparison
`default_nettype none

module tb_retire_mix_monitor
    import retire_mon_pkg::*;
();

    localparam logic [31:0] seed_init      = 32'hb035;
    localparam int          timeout_cycles = 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 retire_valid;
    logic [instr_w-1:0]   retire_instr;
    logic                 report_ready;
    logic                 report_valid;
    logic [cat_idx_w-1:0] report_cat;
    logic [count_w-1:0]   report_count;
    logic                 report_last;
    logic                 overflow;

    integer      seed;
    integer      ready_seed;
    logic        random_ready;
    int          value_errors;
    int          other_errors;
    int          reports_done;
    int          windows_sent;
    int          beat_idx;
    // Expected counts, seven per closed window
    logic [31:0] exp_q[$];
    logic [31:0] exp_cnt[num_cats];
    logic        model_open;

    retire_mix_monitor dut0 (
        .clk(clk), .rst_n(rst_n), .retire_valid(retire_valid), .retire_instr(retire_instr),
        .report_ready(report_ready), .report_valid(report_valid), .report_cat(report_cat),
        .report_count(report_count), .report_last(report_last), .overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model

    function automatic logic [num_cats-1:0] expected_mask(input logic [31:0] instr);
        logic [num_cats-1:0] m;
        m = '0;
        if (instr == start_marker || instr == end_marker) begin
            return m;
        end
        case (instr[6:2])
            opc_arith: begin
                if (instr[25]) begin
                    m[instr[14] ? cat_div : cat_mul] = 1'b1;
                end else begin
                    m[cat_alu] = 1'b1;
                end
            end
            opc_arith_imm, opc_auipc, opc_lui: m[cat_alu] = 1'b1;
            opc_branch, opc_jal, opc_jalr:     m[cat_br] = 1'b1;
            opc_load:                          m[cat_load] = 1'b1;
            opc_store:                         m[cat_store] = 1'b1;
            opc_amo: begin
                m[cat_load]  = 1'b1;
                m[cat_store] = 1'b1;
            end
            opc_system, opc_fence:             m[cat_misc] = 1'b1;
            default:                           m = '0;
        endcase
        return m;
    endfunction

    task automatic model_retire(input logic [31:0] instr);
        logic [num_cats-1:0] m;
        m = expected_mask(instr);
        if (instr == start_marker) begin
            for (int i = 0; i < num_cats; i++) begin
                exp_cnt[i] = '0;
            end
            model_open = 1'b1;
        end else if (model_open && instr == end_marker) begin
            for (int i = 0; i < num_cats; i++) begin
                exp_q.push_back(exp_cnt[i]);
            end
            model_open = 1'b0;
        end else if (model_open) begin
            for (int i = 0; i < num_cats; i++) begin
                exp_cnt[i] = exp_cnt[i] + 32'(m[i]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers

    function automatic logic [4:0] opcode_at(input int idx);
        case (idx)
            0:       return opc_arith;
            1:       return opc_arith_imm;
            2:       return opc_auipc;
            3:       return opc_lui;
            4:       return opc_branch;
            5:       return opc_jal;
            6:       return opc_jalr;
            7:       return opc_load;
            8:       return opc_store;
            9:       return opc_amo;
            10:      return opc_fence;
            default: return opc_system;
        endcase
    endfunction

    function automatic logic [31:0] make_instr(input logic [4:0] opc, input logic [2:0] f3,
                                               input logic b25);
        logic [31:0] w;
        w        = $random(seed);
        w[6:0]   = {opc, 2'b11};
        w[14:12] = f3;
        w[25]    = b25;
        // Never hit a marker by accident
        if (w == start_marker || w == end_marker) begin
            w[7] = ~w[7];
        end
        return w;
    endfunction

    task automatic retire(input logic [31:0] instr);
        @(negedge clk);
        retire_valid = 1'b1;
        retire_instr = instr;
        model_retire(instr);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            retire_valid = 1'b0;
        end
    endtask

    task automatic random_burst(input int n);
        for (int i = 0; i < n; i++) begin
            retire(make_instr(opcode_at($unsigned($random(seed)) % 12), 3'($random(seed)),
                              1'($random(seed))));
            if ($unsigned($random(seed)) % 4 == 0) begin
                idle(1);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("error: time %0t signal %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic wait_reports(input int target);
        int cycles;
        cycles = 0;
        @(negedge clk);
        retire_valid = 1'b0;
        while (reports_done < target && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (reports_done < target) begin
            other_errors++;
            $display("Timed out waiting for report number %0d", target);
        end
    endtask

    //////////////////////////////////////////////////
    // Report comparison

    always @(posedge clk) begin
        if (rst_n && report_valid && report_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("A report beat arrived at time %0t with no report expected", $time);
            end else begin
                check_value("report_cat", 32'(beat_idx), 32'(report_cat));
                check_value("report_count", exp_q.pop_front(), report_count);
                check_value("report_last", 32'(beat_idx == num_cats - 1), 32'(report_last));
                if (beat_idx == num_cats - 1) begin
                    beat_idx = 0;
                    reports_done++;
                end else begin
                    beat_idx++;
                end
            end
        end
    end

    // Ready is random only in the back-pressure phase
    always @(negedge clk) begin
        if (random_ready) begin
            report_ready = ($unsigned($random(ready_seed)) % 3) != 0;
        end else begin
            report_ready = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        seed         = seed_init;
        ready_seed   = ~seed_init;
        rst_n        = 1'b0;
        retire_valid = 1'b0;
        retire_instr = '0;
        report_ready = 1'b0;
        random_ready = 1'b0;
        value_errors = 0;
        other_errors = 0;
        reports_done = 0;
        windows_sent = 0;
        beat_idx     = 0;
        model_open   = 1'b0;
        for (int i = 0; i < num_cats; i++) begin
            exp_cnt[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Traffic before any window is ignored
        random_burst(10);

        // Directed corner cases with ready held high
        retire(start_marker);
        retire(make_instr(opc_amo, 3'b010, 1'b0));
        retire(make_instr(opc_arith, 3'b000, 1'b1));
        retire(make_instr(opc_arith, 3'b100, 1'b1));
        retire(make_instr(opc_arith, 3'b000, 1'b0));
        retire(make_instr(opc_arith_imm, 3'b000, 1'b1));
        retire(make_instr(opc_load, 3'b010, 1'b0));
        retire(make_instr(opc_store, 3'b010, 1'b0));
        retire(end_marker);
        windows_sent++;
        random_burst(4);
        wait_reports(windows_sent);

        // Consecutive random windows under back-pressure
        random_ready = 1'b1;
        retire(start_marker);
        for (int w = 0; w < 6; w++) begin
            random_burst(12 + $unsigned($random(seed)) % 30);
            retire(end_marker);
            windows_sent++;
            random_burst(3);
            // Next window opens while the report drains, within buffer depth
            if (w != 5) begin
                retire(start_marker);
                random_burst(5);
            end
            wait_reports(windows_sent);
        end

        random_ready = 1'b0;
        idle(5);
        check_value("overflow", 32'h0, 32'(overflow));
        if (exp_q.size() != 0 || beat_idx != 0) begin
            other_errors++;
            $display("Some expected report beats never arrived");
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* flist.f */
src/retire_mon_pkg.sv
src/retire_event_if.sv
src/retire_classifier.sv
src/event_fifo.sv
src/mix_counter_bank.sv
src/retire_mix_monitor.sv
tests/retire_mix_properties.sv
tests/tb_retire_mix_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the retire mix monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_retire_mix_monitor \
    -f flist.f \
    --Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    exit 1
fi
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
